// ==== dv/ulaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_macros.svh"

module ulaTb;
   import ulaPkg::*;

   // Run ends early in frame 17, one spare frame of cycles
   localparam int FrameCycles = `ULA_LINE_CLOCKS * `ULA_FRAME_LINES;
   localparam int CycleLimit  = 18 * FrameCycles;

   logic        clk7;
   logic        rst_n;
   logic [7:0]  addr;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        ear;
   logic [4:0]  kbd;
   logic        issue2Keyboard;
   logic        mic;
   logic        spk;
   logic [13:0] va;
   logic [7:0]  vramData;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;
   logic        hsync;
   logic        vsync;
   logic        int_n;

   // Model raster, previous cycle and column register
   hCount_t     mh;
   hCount_t     prevH;
   vCount_t     mv;
   vCount_t     prevV;
   logic [4:0]  mcol;
   int          frame;
   // Expected port state
   logic        expMic;
   logic        expSpk;
   colour3_t    expBorder;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [31:0] lfsr = 32'h2dd1_ffe9;

   ulaTop DUT (
      .clk7(clk7), .rst_n(rst_n), .addr(addr), .iorq_n(iorq_n), .rd_n(rd_n),
      .wr_n(wr_n), .din(din), .dout(dout), .ear(ear), .kbd(kbd),
      .issue2Keyboard(issue2Keyboard), .mic(mic), .spk(spk), .va(va),
      .vramData(vramData), .r(r), .g(g), .b(b),
      .hsync(hsync), .vsync(vsync), .int_n(int_n)
   );

   initial clk7 = 1'b0;
   always #20 clk7 = ~clk7;

   ////////////////////////////////////////////////////////////
   // Reference functions
   ////////////////////////////////////////////////////////////

   // Taps 32,22,2,1
   function automatic logic [31:0] lfsrStep(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   // Screen fill, every address bit counts
   function automatic ulaByte_t vramByte(input vramAddr_t a);
      return a[7:0] ^ {a[13:8], a[13:12]} ^ 8'h5A;
   endfunction

   function automatic vramAddr_t bitmapAddress(input vCount_t v, input logic [4:0] col);
      return {1'b0, v[7:6], v[2:0], v[5:3], col};
   endfunction

   function automatic vramAddr_t attrAddress(input vCount_t v, input logic [4:0] col);
      return {1'b0, 3'b110, v[7:3], col};
   endfunction

   function automatic colour3_t level(input logic on, input logic bright);
      if (!on) return 3'd0;
      return bright ? `ULA_LEVEL_FULL : `ULA_LEVEL_HALF;
   endfunction

   // Result packed as r, g, b
   function automatic logic [8:0] pixelRgb(input logic bit7, input ulaByte_t attr,
                                           input logic phase);
      logic     ink;
      colour3_t grb;
      ink = bit7 ^ (attr[7] & phase);
      grb = ink ? attr[2:0] : attr[5:3];
      return {level(grb[1], attr[6]), level(grb[2], attr[6]), level(grb[0], attr[6])};
   endfunction

   function automatic logic decoded(input ulaByte_t a);
      return !a[0] && (a != 8'hF4);
   endfunction

   function automatic ulaByte_t expectedRead(input ulaByte_t a, input logic [4:0] keys,
                                             input logic earIn, input logic issue2);
      logic earMix;
      earMix = issue2 ? (earIn ^ (expSpk | expMic)) : (earIn ^ expSpk);
      return decoded(a) ? {1'b1, earMix, 1'b1, keys} : 8'hFF;
   endfunction

   // Paper lines under test, around character and third edges
   function automatic logic checkedLine(input vCount_t v);
      return v inside {0, 1, 7, 8, 63, 64, 65, 127, 128, 191};
   endfunction

   ////////////////////////////////////////////////////////////
   // Check and stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic drawBits(input int count, output logic [7:0] value);
      value = '0;
      for (int k = 0; k < count; k++) begin
         lfsr  = lfsrStep(lfsr);
         value = {value[6:0], lfsr[0]};
      end
   endtask

   task automatic busIdle();
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
   endtask

   // Strobe one write, then check mic and spk a cycle on
   task automatic portWrite(input ulaByte_t a, input ulaByte_t d);
      @(posedge clk7);
      #2;
      addr   = a;
      din    = d;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      @(posedge clk7);
      #2;
      busIdle();
      if (decoded(a)) begin
         {expSpk, expMic, expBorder} = d[4:0];
      end
      @(negedge clk7);
      checkValue("mic", mic, expMic);
      checkValue("spk", spk, expSpk);
   endtask

   task automatic portRead(input ulaByte_t a, input logic [4:0] keys, input logic earIn,
                           input logic issue2);
      @(posedge clk7);
      #2;
      addr           = a;
      kbd            = keys;
      ear            = earIn;
      issue2Keyboard = issue2;
      iorq_n         = 1'b0;
      rd_n           = 1'b0;
      @(negedge clk7);
      checkValue("dout", dout, expectedRead(a, keys, earIn, issue2));
      @(posedge clk7);
      #2;
      busIdle();
   endtask

   // Mid border line, a few clocks after the last write
   task automatic borderCheck(input colour3_t c);
      repeat (10) @(negedge clk7);
      while (!(mv >= `ULA_PAPER_LINES && mh == 100)) @(negedge clk7);
      checkValue("border rgb", {r, g, b}, pixelRgb(1'b0, {2'b00, c, 3'b000}, 1'b0));
   endtask

   ////////////////////////////////////////////////////////////
   // Model counters and timeout
   ////////////////////////////////////////////////////////////

   always @(posedge clk7) begin
      if (!rst_n) begin
         mh    <= '0;
         mv    <= '0;
         prevH <= '0;
         prevV <= '0;
         mcol  <= '0;
         frame <= 0;
      end else begin
         prevH <= mh;
         prevV <= mv;
         if (mh[2:0] == 3'd3) mcol <= mh[7:3];
         if (mh == `ULA_LINE_CLOCKS - 1) begin
            mh <= '0;
            if (mv == `ULA_FRAME_LINES - 1) begin
               mv    <= '0;
               frame <= frame + 1;
            end else begin
               mv <= mv + 1'b1;
            end
         end else begin
            mh <= mh + 1'b1;
         end
      end
   end

   always @(posedge clk7) begin
      cycles <= cycles + 1;
      if (cycles == CycleLimit) begin
         $display("Timeout: run did not reach frame 17 within %0d cycles", CycleLimit);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Screen memory answers in the same cycle
   assign vramData = vramByte(va);

   ////////////////////////////////////////////////////////////
   // Per-cycle checks at the falling edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk7) begin : cycleCheck
      int       x;
      ulaByte_t bmp;
      ulaByte_t attr;
      if (rst_n) begin
         // Syncs lag the counters by one clock
         checkValue("hsync", hsync, !((prevH >= `ULA_HSYNC_START) &&
                    (prevH < `ULA_HSYNC_START + `ULA_HSYNC_LENGTH)));
         checkValue("vsync", vsync, !((prevV >= `ULA_VSYNC_START) &&
                    (prevV < `ULA_VSYNC_START + `ULA_VSYNC_LINES)));
         checkValue("int_n", int_n, !((prevV == `ULA_VSYNC_START) &&
                    (prevH < `ULA_INT_LENGTH)));
         if ((frame == 0 || frame == 16) && checkedLine(mv)) begin
            // Fetch slots 8..15 of every 16 clocks
            if (mh < `ULA_PAPER_WIDTH && mh[3]) begin
               checkValue("va", va, mh[1] ? attrAddress(mv, mcol) : bitmapAddress(mv, mcol));
            end
            if (mh >= `ULA_PIXEL_DELAY && mh < `ULA_PIXEL_DELAY + `ULA_PAPER_WIDTH) begin
               x    = mh - `ULA_PIXEL_DELAY;
               bmp  = vramByte(bitmapAddress(mv, x[7:3]));
               attr = vramByte(attrAddress(mv, x[7:3]));
               // Flash phase is bit 4 of the frame number
               checkValue("pixel rgb", {r, g, b}, pixelRgb(bmp[7 - x[2:0]], attr, frame[4]));
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      logic [7:0] value;
      logic [7:0] port;
      rst_n          = 1'b0;
      addr           = 8'hFF;
      din            = 8'h00;
      ear            = 1'b0;
      kbd            = 5'h1F;
      issue2Keyboard = 1'b0;
      busIdle();
      expMic         = 1'b0;
      expSpk         = 1'b0;
      expBorder      = `ULA_BORDER_RESET;
      repeat (8) @(posedge clk7);
      #2;
      rst_n = 1'b1;

      // Reset state
      @(negedge clk7);
      checkValue("reset syncs", {hsync, vsync, int_n}, 3'b111);
      checkValue("idle dout", dout, 8'hFF);
      checkValue("reset mic", mic, 1'b0);
      checkValue("reset spk", spk, 1'b0);
      while (!(mv == 250 && mh == 100)) @(negedge clk7);
      checkValue("reset border rgb", {r, g, b}, {`ULA_LEVEL_HALF, 6'd0});

      // Reads, with mic and spk stirred now and then
      for (int i = 0; i < 48; i++) begin
         if (i % 6 == 0) begin
            drawBits(2, value);
            portWrite(8'hFE, {3'b000, value[1:0], `ULA_BORDER_RESET});
         end
         drawBits(8, port);
         case (i % 4)
            0:       port = 8'hFE;
            1:       port = port | 8'h01;
            2:       port = 8'hF4;
            default: port = port;
         endcase
         drawBits(7, value);
         portRead(port, value[4:0], value[5], value[6]);
      end

      // Every border colour
      for (int c = 0; c < 8; c++) begin
         drawBits(2, value);
         portWrite(8'hFE, {3'b000, value[1:0], 3'(c)});
         borderCheck(expBorder);
      end

      // Cyan, then writes that must be ignored
      portWrite(8'hFE, 8'h05);
      portWrite(8'hFF, 8'h1A);
      portWrite(8'hF4, 8'h1A);
      borderCheck(3'd5);

      // Frame 16 pixel checks run in cycleCheck
      while (frame < 17) @(negedge clk7);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/ulaPkg.sv
verilog/ulaFetchIf.sv
verilog/ulaPortDecoder.sv
verilog/ulaRasterTiming.sv
verilog/ulaVideoFetch.sv
verilog/ulaPixelOutput.sv
verilog/ulaTop.sv
dv/ulaTb.sv

// ==== verilog/ulaFetchIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ulaFetchIf;
   import ulaPkg::*;

   // Bytes latched from VRAM
   ulaByte_t bitmapData;
   ulaByte_t attrData;

   // One-cycle strobes, both on low bits 4 of hCount
   logic serializerLoad;
   logic attrOutputLoad;

   // High over the paper window of the output stage
   logic videoEnable;

   // Fetch side drives everything
   modport fetch (output bitmapData, attrData, serializerLoad, attrOutputLoad, videoEnable);

   // Pixel side only looks
   modport pixel (input bitmapData, attrData, serializerLoad, attrOutputLoad, videoEnable);

endinterface

`default_nettype wire

// ==== verilog/ulaPixelOutput.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_macros.svh"

module ulaPixelOutput (
   input  wire logic              clk7,
   input  wire logic              rst_n,
   ulaFetchIf.pixel               pixel,
   input  wire ulaPkg::colour3_t  border,
   input  wire logic              flashPhase,
   output ulaPkg::colour3_t       r,
   output ulaPkg::colour3_t       g,
   output ulaPkg::colour3_t       b
);
   import ulaPkg::*;

   ulaByte_t serializer;
   ulaByte_t attrInput;
   ulaByte_t attrOutput;
   logic     flashBit;
   logic     brightBit;
   colour3_t inkColour;
   colour3_t paperColour;
   logic     pixelBit;
   igrb_t    pixelColour;

   // Map one GRB bit to its channel level
   function automatic colour3_t channelLevel(input logic on, input logic bright);
      colour3_t level;
      level = 3'd0;
      if (on) begin
         level = bright ? `ULA_LEVEL_FULL : `ULA_LEVEL_HALF;
      end
      return level;
   endfunction

   ////////////////////////////////////////////////////////////
   // Serializer
   ////////////////////////////////////////////////////////////

   // Msb goes out first
   always_ff @(posedge clk7) begin
      if (pixel.serializerLoad) begin
         serializer <= pixel.bitmapData;
      end else begin
         serializer <= {serializer[6:0], 1'b0};
      end
   end

   ////////////////////////////////////////////////////////////
   // Attribute output
   ////////////////////////////////////////////////////////////

   // Border becomes paper, ink black, no bright or flash
   assign attrInput = pixel.videoEnable ? pixel.attrData : {2'b00, border, 3'b000};

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         attrOutput <= '0;
      end else if (pixel.attrOutputLoad) begin
         attrOutput <= attrInput;
      end
   end

   assign flashBit    = attrOutput[7];
   assign brightBit   = attrOutput[6];
   assign paperColour = attrOutput[5:3];
   assign inkColour   = attrOutput[2:0];

   ////////////////////////////////////////////////////////////
   // Colour
   ////////////////////////////////////////////////////////////

   // Flash cells swap ink and paper in the upper 16 frames
   assign pixelBit = serializer[7] ^ (flashBit & flashPhase);

   assign pixelColour = pixelBit ? {brightBit, inkColour} : {brightBit, paperColour};

   // GRB order, green on top
   assign g = channelLevel(pixelColour[2], pixelColour[3]);
   assign r = channelLevel(pixelColour[1], pixelColour[3]);
   assign b = channelLevel(pixelColour[0], pixelColour[3]);

endmodule

`default_nettype wire

// ==== verilog/ulaPkg.sv ====
`default_nettype none

package ulaPkg;

   ////////////////////////////////////////////////////////////
   // Raster counters
   ////////////////////////////////////////////////////////////

   // Pixel clock within a line, 0..447
   typedef logic [8:0] hCount_t;

   // Line within a frame, 0..311
   typedef logic [8:0] vCount_t;

   ////////////////////////////////////////////////////////////
   // Video memory and colour
   ////////////////////////////////////////////////////////////

   // 16K of screen memory
   typedef logic [13:0] vramAddr_t;

   // Bitmap byte, attribute byte or CPU data
   typedef logic [7:0] ulaByte_t;

   // One 3-level channel, or a GRB colour index
   typedef logic [2:0] colour3_t;

   // Bright on top of GRB
   typedef logic [3:0] igrb_t;

endpackage

`default_nettype wire

// ==== verilog/ulaPortDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_macros.svh"

module ulaPortDecoder (
   input  wire logic         clk7,
   input  wire logic         rst_n,
   input  wire logic [7:0]   addr,
   input  wire logic         iorq_n,
   input  wire logic         rd_n,
   input  wire logic         wr_n,
   input  wire logic [7:0]   din,
   output logic [7:0]        dout,
   input  wire logic         ear,
   input  wire logic [4:0]   kbd,
   input  wire logic         issue2Keyboard,
   output logic              mic,
   output logic              spk,
   output ulaPkg::colour3_t  border
);
   import ulaPkg::*;

   // Even address that the MMU port claims instead
   localparam ulaByte_t MmuPortAddr = 8'hF4;

   logic     feSelect;
   logic     feWrite;
   logic     feRead;
   logic     earProcessed;

   // Any even port except F4 is the ULA
   assign feSelect = !iorq_n && !addr[0] && (addr != MmuPortAddr);
   assign feWrite  = feSelect && !wr_n;
   assign feRead   = feSelect && !rd_n;

   ////////////////////////////////////////////////////////////
   // Port FE write side
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= `ULA_BORDER_RESET;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (feWrite) begin
         // Bits 2..0 border, bit 3 mic, bit 4 speaker
         border <= din[2:0];
         mic    <= din[3];
         spk    <= din[4];
      end
   end

   ////////////////////////////////////////////////////////////
   // Port FE read side
   ////////////////////////////////////////////////////////////

   // Issue 2 boards also let mic leak into ear
   assign earProcessed = issue2Keyboard ? (ear ^ (spk | mic)) : (ear ^ spk);

   always_comb begin
      // Idle bus reads as all ones
      dout = 8'hFF;
      if (feRead) begin
         dout = {1'b1, earProcessed, 1'b1, kbd};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ulaRasterTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_macros.svh"

module ulaRasterTiming (
   input  wire logic        clk7,
   input  wire logic        rst_n,
   output ulaPkg::hCount_t  hCount,
   output ulaPkg::vCount_t  vCount,
   output logic             flashPhase,
   output logic             hsync,
   output logic             vsync,
   output logic             int_n
);
   import ulaPkg::*;

   logic                        lineEnd;
   logic                        frameEnd;
   logic                        hsyncWindow;
   logic                        vsyncWindow;
   logic                        intWindow;
   logic                        flashTick;
   logic [`ULA_FLASH_BITS-1:0]  flashCount;

   ////////////////////////////////////////////////////////////
   // Pixel and line counters
   ////////////////////////////////////////////////////////////

   assign lineEnd  = (hCount == hCount_t'(`ULA_LINE_CLOCKS - 1));
   assign frameEnd = (vCount == vCount_t'(`ULA_FRAME_LINES - 1));

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hCount <= '0;
         vCount <= '0;
      end else if (lineEnd) begin
         hCount <= '0;
         // Line step only at end of line
         vCount <= frameEnd ? '0 : vCount + 1'b1;
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Sync and interrupt
   ////////////////////////////////////////////////////////////

   // Counter ranges, registered below so outputs lag one clock
   assign hsyncWindow = (hCount >= `ULA_HSYNC_START) &&
                        (hCount < `ULA_HSYNC_START + `ULA_HSYNC_LENGTH);
   assign vsyncWindow = (vCount >= `ULA_VSYNC_START) &&
                        (vCount < `ULA_VSYNC_START + `ULA_VSYNC_LINES);
   // Interrupt at start of the first vsync line
   assign intWindow   = (vCount == `ULA_VSYNC_START) && (hCount < `ULA_INT_LENGTH);

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hsync <= 1'b1;
         vsync <= 1'b1;
         int_n <= 1'b1;
      end else begin
         hsync <= !hsyncWindow;
         vsync <= !vsyncWindow;
         int_n <= !intWindow;
      end
   end

   // Flash counter, one step per frame at vsync
   assign flashTick = (hCount == '0) && (vCount == `ULA_VSYNC_START);

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= '0;
      end else if (flashTick) begin
         flashCount <= flashCount + 1'b1;
      end
   end

   // Top bit toggles every 16 frames
   assign flashPhase = flashCount[`ULA_FLASH_BITS-1];

endmodule

`default_nettype wire

// ==== verilog/ulaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulaTop (
   input  wire logic         clk7,
   input  wire logic         rst_n,
   // CPU side
   input  wire logic [7:0]   addr,
   input  wire logic         iorq_n,
   input  wire logic         rd_n,
   input  wire logic         wr_n,
   input  wire logic [7:0]   din,
   output logic [7:0]        dout,
   // Keyboard, tape and sound
   input  wire logic         ear,
   input  wire logic [4:0]   kbd,
   input  wire logic         issue2Keyboard,
   output logic              mic,
   output logic              spk,
   // Screen memory
   output logic [13:0]       va,
   input  wire logic [7:0]   vramData,
   // Video out
   output logic [2:0]        r,
   output logic [2:0]        g,
   output logic [2:0]        b,
   output logic              hsync,
   output logic              vsync,
   output logic              int_n
);
   import ulaPkg::*;

   hCount_t  hCount;
   vCount_t  vCount;
   logic     flashPhase;
   colour3_t border;

   // Bytes and strobes from fetch to pixel output
   ulaFetchIf fetchBus ();

   ulaPortDecoder uPorts (
      .clk7(clk7), .rst_n(rst_n),
      .addr(addr), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .din(din), .dout(dout),
      .ear(ear), .kbd(kbd), .issue2Keyboard(issue2Keyboard),
      .mic(mic), .spk(spk), .border(border)
   );

   ulaRasterTiming uRaster (
      .clk7(clk7), .rst_n(rst_n),
      .hCount(hCount), .vCount(vCount), .flashPhase(flashPhase),
      .hsync(hsync), .vsync(vsync), .int_n(int_n)
   );

   ulaVideoFetch uFetch (
      .clk7(clk7), .rst_n(rst_n),
      .hCount(hCount), .vCount(vCount),
      .vramData(vramData), .va(va), .fetch(fetchBus.fetch)
   );

   ulaPixelOutput uPixel (
      .clk7(clk7), .rst_n(rst_n),
      .pixel(fetchBus.pixel), .border(border), .flashPhase(flashPhase),
      .r(r), .g(g), .b(b)
   );

endmodule

`default_nettype wire

// ==== verilog/ulaVideoFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_macros.svh"

module ulaVideoFetch (
   input  wire logic             clk7,
   input  wire logic             rst_n,
   input  wire ulaPkg::hCount_t  hCount,
   input  wire ulaPkg::vCount_t  vCount,
   input  wire ulaPkg::ulaByte_t vramData,
   output ulaPkg::vramAddr_t     va,
   ulaFetchIf.fetch              fetch
);
   import ulaPkg::*;

   // Phases inside each 8-clock character cell
   localparam logic [2:0] ColumnPhase = 3'd3;
   localparam logic [2:0] LoadPhase   = 3'd4;

   // Byte loads one clock ahead of its first pixel, so the
   // output window opens on the 8-clock boundary before that
   localparam int VideoStart = `ULA_PIXEL_DELAY - 5;
   localparam int VideoEnd   = VideoStart + `ULA_PAPER_WIDTH - 1;

   logic       paperLine;
   logic       fetchWindow;
   logic [3:0] slot;
   logic       bitmapSlot;
   logic       attrSlot;
   logic [4:0] column;
   vramAddr_t  bitmapAddr;
   vramAddr_t  attrAddr;
   ulaByte_t   bitmapReg;
   ulaByte_t   attrReg;

   ////////////////////////////////////////////////////////////
   // Fetch slots
   ////////////////////////////////////////////////////////////

   assign paperLine   = (vCount < `ULA_PAPER_LINES);
   assign fetchWindow = paperLine && (hCount < `ULA_PAPER_WIDTH);
   assign slot        = hCount[3:0];

   // Slots 8,9,12,13 bitmap; 10,11,14,15 attribute
   assign bitmapSlot = fetchWindow && slot[3] && !slot[1];
   assign attrSlot   = fetchWindow && slot[3] && slot[1];

   // Column for the next pair of fetches
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         column <= '0;
      end else if (hCount[2:0] == ColumnPhase) begin
         column <= hCount[7:3];
      end
   end

   ////////////////////////////////////////////////////////////
   // VRAM address
   ////////////////////////////////////////////////////////////

   // Third, pixel row, character row, then column
   assign bitmapAddr = {1'b0, vCount[7:6], vCount[2:0], vCount[5:3], column};
   // Attribute block sits at 1800 hex
   assign attrAddr   = {1'b0, 3'b110, vCount[7:3], column};

   assign va = attrSlot ? attrAddr : bitmapAddr;

   ////////////////////////////////////////////////////////////
   // Data latches
   ////////////////////////////////////////////////////////////

   // Second clock of each slot pair captures the byte
   always_ff @(posedge clk7) begin
      if (bitmapSlot && slot[0]) begin
         bitmapReg <= vramData;
      end
      if (attrSlot && slot[0]) begin
         attrReg <= vramData;
      end
   end

   assign fetch.bitmapData = bitmapReg;
   assign fetch.attrData   = attrReg;

   // Output stage control
   assign fetch.videoEnable    = paperLine && (hCount >= VideoStart) && (hCount <= VideoEnd);
   assign fetch.serializerLoad = fetch.videoEnable && (hCount[2:0] == LoadPhase);
   // Attribute register also tracks border outside paper
   assign fetch.attrOutputLoad = (hCount[2:0] == LoadPhase);

endmodule

`default_nettype wire

// ==== verilog/ula_macros.svh ====
`ifndef ULA_MACROS_SVH
`define ULA_MACROS_SVH

// Frame geometry in pixel clocks and lines
`define ULA_LINE_CLOCKS   448
`define ULA_FRAME_LINES   312
`define ULA_PAPER_WIDTH   256
`define ULA_PAPER_LINES   192

// Counter value minus pixel column at which that pixel is on screen
`define ULA_PIXEL_DELAY   13

// Sync placement
`define ULA_HSYNC_START   344
`define ULA_HSYNC_LENGTH  32
// Vertical sync line, also interrupt line and flash tick line
`define ULA_VSYNC_START   248
`define ULA_VSYNC_LINES   4
`define ULA_INT_LENGTH    32

// Border after reset is red
`define ULA_BORDER_RESET  3'd2

// Channel levels for normal and bright colours
`define ULA_LEVEL_HALF    3'd5
`define ULA_LEVEL_FULL    3'd7

`define ULA_FLASH_BITS    5

`endif
